/* cpuFrontEnd.f */
+incdir+common
common/cpuPkg.sv
source/pulseSlower.sv
frontEnd/interruptController.sv
frontEnd/instructionLoader.sv
frontEnd/opcodeDecoder.sv
source/cycleSequencer.sv
source/cpuFrontEnd.sv
verification/cpuFrontEndTb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --timing --assert
TOP      = cpuFrontEndTb
FILELIST = cpuFrontEnd.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "Done: no errors" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* verification/cpuFrontEndTb.sv */
`include "cpu_consts.svh"

module cpuFrontEndTb import cpuPkg::*; ();
    logic clk, rst, ready;
    logic nonMaskableInterrupt, interruptRequest;  // Active low
    logic [7:0] dataBusInput;
    logic [15:0] addressBus;
    logic sync, cycleStrobe;
    decoded_t currentOp;

    logic [7:0] memory [0:65535];
    logic [7:0] validOps [0:15];
    logic [31:0] lfsrState;

    logic [15:0] modelPc;
    logic [2:0] modelCount;  // 0 is the fetch step
    logic modelBooting, modelResetPending, modelIFlag, nmiLatched;
    logic [15:0] modelVector;
    logic [7:0] modelVectorLow;
    decoded_t modelOp;
    int strobeCount;
    string testName;

    cpuFrontEnd u_dut (
        .clk(clk),
        .rst(rst),
        .ready(ready),
        .nonMaskableInterrupt(nonMaskableInterrupt),
        .interruptRequest(interruptRequest),
        .dataBusInput(dataBusInput),
        .addressBus(addressBus),
        .sync(sync),
        .cycleStrobe(cycleStrobe),
        .currentOp(currentOp)
    );

    assign dataBusInput = memory[addressBus];  // Combinational read

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [7:0] takeBits(input int count);
        logic [7:0] bits;
        logic feedback;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            feedback = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
            lfsrState = {lfsrState[30:0], feedback};
            bits = {bits[6:0], feedback};
        end
        return bits;
    endfunction

    // 6502 modes and bus cycles of the opcodes that the memory holds
    function automatic decoded_t decodeReference(input logic [7:0] opcode);
        decoded_t result;
        case (opcode)
            8'h00: result = '{brk, implied, 2'd1, 3'(`INTERRUPT_CYCLES)};
            8'h58: result = '{clearI, implied, 2'd1, 3'd2};
            8'h78: result = '{setI, implied, 2'd1, 3'd2};
            8'hA9, 8'hA2, 8'hD0: result = '{plain, (opcode == 8'hD0) ? relative : immediate,
                                             2'd2, 3'd2};
            8'hA5, 8'hA6: result = '{plain, zeroPage, 2'd2, 3'd3};
            8'hB5: result = '{plain, zeroPageX, 2'd2, 3'd4};
            8'hAD, 8'hAE: result = '{plain, absolute, 2'd3, 3'd4};
            8'hBD, 8'hB9: result = '{plain, absoluteX, 2'd3, 3'd4};
            8'hA1: result = '{plain, indirectX, 2'd2, 3'd6};
            8'hB1: result = '{plain, indirectY, 2'd2, 3'd5};
            default: result = '{plain, implied, 2'd1, 3'd2};  // CLC
        endcase
        return result;
    endfunction

    // Advances the model by one bus cycle, returns {sync, address}
    function automatic logic [16:0] referenceStep(input logic irqLow);
        logic [15:0] address;
        logic [2:0] offset;
        logic sawFetch;
        intSource_e source;
        sawFetch = 1'b0;
        if (modelCount == 3'd0) begin
            source = none;
            if (modelResetPending)
                source = reset;
            else if (nmiLatched)
                source = nmi;
            else if (irqLow && !modelIFlag)
                source = irq;
            address = modelPc;
            sawFetch = !modelBooting;
            modelBooting = 1'b0;
            modelVector = `VECTOR_IRQ;  // Fetched BRK too
            if (source != none) begin
                modelOp = decodeReference(`BRK_OPCODE);
                modelIFlag = 1'b1;
                modelResetPending = 1'b0;
                if (source == nmi)
                    nmiLatched = 1'b0;
                if (source == reset)
                    modelVector = `VECTOR_RESET;
                else if (source == nmi)
                    modelVector = `VECTOR_NMI;
            end
            else begin
                modelOp = decodeReference(memory[modelPc]);
            end
            modelCount = 3'd1;
        end
        else begin
            if (modelOp.opClass == brk && modelCount >= modelOp.cycles - 3'd2) begin
                address = modelVector + {15'd0, modelCount == modelOp.cycles - 3'd1};
            end
            else begin
                offset = (modelCount < {1'b0, modelOp.bytes}) ? modelCount
                                                                : {1'b0, modelOp.bytes} - 3'd1;
                address = modelPc + {13'd0, offset};
            end
            if (modelCount == 3'd1) begin
                if (modelOp.opClass == setI || modelOp.opClass == brk)
                    modelIFlag = 1'b1;
                else if (modelOp.opClass == clearI)
                    modelIFlag = 1'b0;
            end
            if (modelCount == modelOp.cycles - 3'd1) begin
                modelCount = 3'd0;
                if (modelOp.opClass == brk)
                    modelPc = {memory[address], modelVectorLow};
                else
                    modelPc = modelPc + {14'd0, modelOp.bytes};
            end
            else begin
                if (modelOp.opClass == brk && modelCount == modelOp.cycles - 3'd2)
                    modelVectorLow = memory[address];
                modelCount = modelCount + 3'd1;
            end
        end
        return {sawFetch, address};
    endfunction

    task automatic checkValue(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Fail %s %s: expected %h, actual %h", testName, what, expected, actual);
            $display("Done: errors found");
            $fatal(1);
        end
    endtask

    // Interrupt windows are keyed to the number of bus cycles seen so far
    task automatic driveInputs();
        logic nmiLow;
        logic irqLow;
        nmiLow = (strobeCount >= 40 && strobeCount < 60)
                 || (strobeCount >= 150 && strobeCount < 170);
        irqLow = (strobeCount < 8) || (strobeCount >= 10 && strobeCount < 20)
                 || (strobeCount >= 150 && strobeCount < 190);
        if (nmiLow && nonMaskableInterrupt)
            nmiLatched = 1'b1;  // Seen before the next bus cycle
        nonMaskableInterrupt = !nmiLow;
        interruptRequest = !irqLow;
        ready = (takeBits(2) != 8'd0);
        if (strobeCount < 8)
            testName = "reset vector";
        else if (strobeCount < 25)
            testName = "irq mask";
        else if (strobeCount < 40)
            testName = "straight line";
        else if (strobeCount < 150)
            testName = "nmi";
        else
            testName = "nmi over irq";
    endtask

    always @(posedge clk) begin : compareCycle
        logic [16:0] expected;
        logic wasFetch;
        if (!rst && cycleStrobe) begin
            strobeCount++;
            wasFetch = (modelCount == 3'd0);
            expected = referenceStep(!interruptRequest);
            checkValue("address", 32'(expected[15:0]), 32'(addressBus));
            checkValue("sync", 32'(expected[16]), 32'(sync));
            if (!wasFetch)
                checkValue("currentOp", 32'({modelOp}), 32'({currentOp}));
        end
        else if (!rst) begin
            checkValue("sync without strobe", 32'd0, 32'(sync));
        end
    end

    initial begin : mainSequence
        int lastCount;
        int waited;
        logic [7:0] pick;
        rst = 1'b1;
        ready = 1'b1;
        nonMaskableInterrupt = 1'b1;
        interruptRequest = 1'b0;  // IRQ low while I is set from reset
        lfsrState = 32'h8dc8;
        testName = "reset vector";
        strobeCount = 0;
        validOps = '{8'h00, 8'h18, 8'h58, 8'h78, 8'hA1, 8'hA2, 8'hA5, 8'hA6,
                     8'hA9, 8'hAD, 8'hAE, 8'hB1, 8'hB5, 8'hB9, 8'hBD, 8'hD0};
        for (int i = 0; i < 65536; i++) begin
            pick = takeBits(4);
            memory[16'(i)] = validOps[pick[3:0]];
        end
        {memory[16'hFFFD], memory[16'hFFFC]} = 16'h0200;
        {memory[16'hFFFF], memory[16'hFFFE]} = 16'h0300;
        {memory[16'hFFFB], memory[16'hFFFA]} = 16'h0500;
        {memory[16'h0200], memory[16'h0201], memory[16'h0202]} = {8'h58, 8'h78, 8'h18};
        {memory[16'h0203], memory[16'h0204], memory[16'h0205]} = {8'h18, 8'h58, 8'h18};
        memory[16'h0500] = 8'h58;  // CLI opens the NMI handler
        modelPc = '0;
        modelCount = '0;
        modelBooting = 1'b1;
        modelResetPending = 1'b1;
        modelIFlag = 1'b1;
        nmiLatched = 1'b0;
        modelVector = '0;
        modelVectorLow = '0;
        modelOp = decodeReference(`BRK_OPCODE);
        repeat (3) @(negedge clk);
        checkValue("strobe in reset", 32'd0, 32'(cycleStrobe));
        checkValue("sync in reset", 32'd0, 32'(sync));
        checkValue("address in reset", 32'd0, 32'(addressBus));
        rst = 1'b0;
        while (strobeCount < 300) begin
            lastCount = strobeCount;
            waited = 0;
            while (strobeCount == lastCount && waited < 200) begin
                @(negedge clk);
                driveInputs();
                waited++;
            end
            if (strobeCount == lastCount) begin
                $display("Timeout: no bus cycle within 200 clocks");
                $display("Done: errors found");
                $fatal(1);
            end
        end
        $display("Done: no errors");
        $finish;
    end

endmodule

/* source/cpuFrontEnd.sv */
module cpuFrontEnd import cpuPkg::*; (
    input  logic clk, rst, ready,
    input  logic nonMaskableInterrupt, interruptRequest,  // Active low
    input  logic [7:0] dataBusInput,
    output logic [15:0] addressBus,
    output logic sync, cycleStrobe,
    output decoded_t currentOp
);
    logic slowPulse;
    logic step, fetchNow, opRetired;
    logic takeInterrupt;
    intSource_e pending;
    fetch_t fetch;
    decoded_t decoded;

    assign cycleStrobe = step;
    assign currentOp   = decoded;

    pulseSlower pulseSlower (
        .clk(clk),
        .rst(rst),
        .slowPulse(slowPulse)
    );

    interruptController interruptController (
        .clk(clk),
        .rst(rst),
        .step(step),
        .nonMaskableInterrupt(nonMaskableInterrupt),
        .interruptRequest(interruptRequest),
        .takeInterrupt(takeInterrupt),
        .opRetired(opRetired),
        .retiredClass(decoded.opClass),
        .pending(pending),
        .iFlag()
    );

    instructionLoader instructionLoader (
        .clk(clk),
        .rst(rst),
        .step(step),
        .fetchNow(fetchNow),
        .dataBusInput(dataBusInput),
        .pending(pending),
        .fetch(fetch),
        .takeInterrupt(takeInterrupt)
    );

    opcodeDecoder opcodeDecoder (
        .fetch(fetch),
        .decoded(decoded)
    );

    cycleSequencer cycleSequencer (
        .clk(clk),
        .rst(rst),
        .slowPulse(slowPulse),
        .ready(ready),
        .dataBusInput(dataBusInput),
        .decoded(decoded),
        .fetchSource(fetch.source),
        .step(step),
        .fetchNow(fetchNow),
        .opRetired(opRetired),
        .addressBus(addressBus),
        .sync(sync)
    );

endmodule

/* source/cycleSequencer.sv */
`include "cpu_consts.svh"

module cycleSequencer import cpuPkg::*; (
    input  logic clk, rst, slowPulse, ready,
    input  logic [7:0] dataBusInput,
    input  decoded_t decoded,
    input  intSource_e fetchSource,
    output logic step, fetchNow, opRetired,
    output logic [15:0] addressBus,
    output logic sync
);
    logic [15:0] pc;
    logic [2:0] stepCount;  // 0 is the fetch cycle
    logic [7:0] vectorLow;
    logic booting;  // Reset sequence, its fetch cycle is hidden
    logic [2:0] lastCount;
    logic [2:0] byteCount;
    logic [2:0] operandOffset;
    logic vectorCycle;
    logic [15:0] vectorBase;

    assign step      = slowPulse & ready;
    assign fetchNow  = (stepCount == 3'd0);
    assign sync      = step & fetchNow & ~booting;
    assign opRetired = step & (stepCount == 3'd1);

    assign lastCount = decoded.cycles - 3'd1;
    assign byteCount = {1'b0, decoded.bytes};

    // Last two cycles of a BRK read the vector
    assign vectorCycle = (decoded.opClass == brk) && !fetchNow
                         && (stepCount >= decoded.cycles - 3'd2);

    always_comb begin
        case (fetchSource)
            reset:   vectorBase = `VECTOR_RESET;
            nmi:     vectorBase = `VECTOR_NMI;
            default: vectorBase = `VECTOR_IRQ;  // IRQ and a fetched BRK
        endcase
    end

    // Operand bytes first, then hold the last one
    assign operandOffset = (stepCount < byteCount) ? stepCount : byteCount - 3'd1;

    assign addressBus = vectorCycle ? vectorBase + {15'd0, stepCount == lastCount}
                                    : pc + {13'd0, operandOffset};

    always_ff @(posedge clk) begin
        if (rst) begin
            pc        <= '0;
            stepCount <= '0;
            booting   <= 1'b1;
        end
        else if (step) begin
            if (fetchNow) begin
                stepCount <= 3'd1;
                booting   <= 1'b0;
            end
            else if (stepCount == lastCount) begin
                stepCount <= '0;
                if (decoded.opClass == brk)
                    pc <= {dataBusInput, vectorLow};
                else
                    pc <= pc + {14'd0, decoded.bytes};
            end
            else begin
                stepCount <= stepCount + 3'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (step && vectorCycle && stepCount != lastCount)
            vectorLow <= dataBusInput;
    end

    syncAtPc: assert property (@(posedge clk) disable iff (rst)
        sync |-> addressBus == pc);

    countInRange: assert property (@(posedge clk) disable iff (rst)
        stepCount != 3'd0 |-> stepCount < decoded.cycles);

endmodule

/* frontEnd/opcodeDecoder.sv */
`include "cpu_consts.svh"

module opcodeDecoder import cpuPkg::*; (
    input  fetch_t fetch,
    output decoded_t decoded
);
    logic [2:0] aaa;
    logic [2:0] bbb;
    logic [1:0] cc;
    addrMode_e mode;
    instrClass_e opClass;

    assign {aaa, bbb, cc} = fetch.opcode;

    always_comb begin
        if (fetch.source != none || fetch.opcode == `BRK_OPCODE)
            opClass = brk;
        else if (fetch.opcode == `SEI_OPCODE)
            opClass = setI;
        else if (fetch.opcode == `CLI_OPCODE)
            opClass = clearI;
        else
            opClass = plain;
    end

    always_comb begin
        mode = implied;
        if (cc == 2'b01) begin
            case (bbb)
                3'b000: mode = indirectX;
                3'b001: mode = zeroPage;
                3'b010: mode = immediate;
                3'b011: mode = absolute;
                3'b100: mode = indirectY;
                3'b101: mode = zeroPageX;
                default: mode = absoluteX;  // abs,Y and abs,X
            endcase
        end
        else if (cc != 2'b11) begin
            case (bbb)
                3'b000: mode = aaa[2] ? immediate : implied;  // LDX/LDY/CPY/CPX #
                3'b001: mode = zeroPage;
                3'b011: mode = absolute;
                3'b100: mode = (cc == 2'b00) ? relative : implied;
                3'b101: mode = zeroPageX;
                3'b111: mode = absoluteX;
                default: mode = implied;
            endcase
        end
    end

    always_comb begin
        decoded.opClass = opClass;
        decoded.mode    = mode;
        case (mode)
            implied:   {decoded.bytes, decoded.cycles} = {2'd1, 3'd2};
            immediate: {decoded.bytes, decoded.cycles} = {2'd2, 3'd2};
            zeroPage:  {decoded.bytes, decoded.cycles} = {2'd2, 3'd3};
            zeroPageX: {decoded.bytes, decoded.cycles} = {2'd2, 3'd4};
            absolute:  {decoded.bytes, decoded.cycles} = {2'd3, 3'd4};
            absoluteX: {decoded.bytes, decoded.cycles} = {2'd3, 3'd4};
            indirectX: {decoded.bytes, decoded.cycles} = {2'd2, 3'd6};
            indirectY: {decoded.bytes, decoded.cycles} = {2'd2, 3'd5};
            default:   {decoded.bytes, decoded.cycles} = {2'd2, 3'd2};
        endcase
        if (opClass == brk) begin
            decoded.mode   = implied;
            decoded.bytes  = 2'd1;
            decoded.cycles = 3'(`INTERRUPT_CYCLES);
        end
    end

endmodule

/* frontEnd/instructionLoader.sv */
`include "cpu_consts.svh"

module instructionLoader import cpuPkg::*; (
    input  logic clk, rst, step, fetchNow,
    input  logic [7:0] dataBusInput,
    input  intSource_e pending,
    output fetch_t fetch,
    output logic takeInterrupt
);
    logic loadNow;
    logic injecting;

    assign loadNow   = step & fetchNow;
    assign injecting = (pending != none);

    // One clock wide since step is
    assign takeInterrupt = loadNow & injecting;

    always_ff @(posedge clk) begin
        if (rst) begin
            fetch.opcode <= `BRK_OPCODE;
            fetch.source <= none;
        end
        else if (loadNow) begin
            if (injecting) begin
                fetch.opcode <= `BRK_OPCODE;  // Bus byte is dropped
            end
            else begin
                fetch.opcode <= dataBusInput;
            end
            fetch.source <= pending;
        end
    end

endmodule

/* frontEnd/interruptController.sv */
module interruptController import cpuPkg::*; (
    input  logic clk, rst, step,
    input  logic nonMaskableInterrupt, interruptRequest,  // Both active low
    input  logic takeInterrupt, opRetired,
    input  instrClass_e retiredClass,
    output intSource_e pending,
    output logic iFlag
);
    logic [2:0] nmiShift;
    logic nmiFall;
    logic nmiLatch;
    logic resetPending;

    // Two flops of synchronizer, third one for the edge
    assign nmiFall = nmiShift[2] & ~nmiShift[1];

    always_ff @(posedge clk) begin
        if (rst) begin
            nmiShift     <= '1;  // Line idles high
            nmiLatch     <= 1'b0;
            resetPending <= 1'b1;
        end
        else begin
            nmiShift     <= {nmiShift[1:0], nonMaskableInterrupt};
            nmiLatch     <= (nmiLatch & ~(takeInterrupt && pending == nmi)) | nmiFall;
            resetPending <= resetPending & ~(takeInterrupt && pending == reset);
        end
    end

    always_comb begin
        if (resetPending)
            pending = reset;
        else if (nmiLatch)
            pending = nmi;
        else if (!interruptRequest && !iFlag)
            pending = irq;  // Level, masked
        else
            pending = none;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            iFlag <= 1'b1;
        end
        else if (step) begin
            if (takeInterrupt) begin
                iFlag <= 1'b1;
            end
            else if (opRetired) begin
                if (retiredClass == setI || retiredClass == brk)
                    iFlag <= 1'b1;
                else if (retiredClass == clearI)
                    iFlag <= 0;
            end
        end
    end

    takeSetsI: assert property (@(posedge clk) disable iff (rst)
        takeInterrupt |=> iFlag);

    takeClearsNmi: assert property (@(posedge clk) disable iff (rst)
        takeInterrupt && pending == nmi && !nmiFall |=> !nmiLatch);

endmodule

/* source/pulseSlower.sv */
`include "cpu_consts.svh"

module pulseSlower (
    input  logic clk, rst,
    output logic slowPulse
);
    localparam int countWidth = $clog2(`SLOW_DIVIDE + 1);

    logic [countWidth-1:0] divideCount;

    // High for the last clock of every bus cycle
    assign slowPulse = (divideCount == countWidth'(`SLOW_DIVIDE - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            divideCount <= '0;
        end
        else if (slowPulse) begin
            divideCount <= '0;  // Wrap
        end
        else begin
            divideCount <= divideCount + 1'b1;
        end
    end

endmodule

/* common/cpuPkg.sv */
package cpuPkg;

    typedef enum logic [3:0] {
        implied,
        immediate,
        zeroPage,
        zeroPageX,
        absolute,
        absoluteX,  // Also covers abs,Y
        indirectX,
        indirectY,
        relative
    } addrMode_e;

    typedef enum logic [1:0] {
        plain,
        setI,
        clearI,
        brk
    } instrClass_e;

    // Ordered by nothing, priority lives in the interrupt controller
    typedef enum logic [1:0] {
        none,
        reset,
        nmi,
        irq
    } intSource_e;

    typedef struct packed {
        instrClass_e opClass;
        addrMode_e   mode;
        logic [1:0]  bytes;
        logic [2:0]  cycles;  // Bus cycles from fetch to next fetch
    } decoded_t;

    typedef struct packed {
        logic [7:0] opcode;
        intSource_e source;  // none for a byte read from memory
    } fetch_t;

endpackage

/* common/cpu_consts.svh */
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Clock cycles per bus cycle
`define SLOW_DIVIDE 4

// Low byte addresses of the vectors, high byte follows at +1
`define VECTOR_NMI   16'hFFFA
`define VECTOR_RESET 16'hFFFC
`define VECTOR_IRQ   16'hFFFE

// Opcode forced into the opcode register when an interrupt is accepted
`define BRK_OPCODE 8'h00

// Bus cycles of an interrupt or reset sequence, fetch included
`define INTERRUPT_CYCLES 7

// Opcodes that touch the I flag
`define SEI_OPCODE 8'h78
`define CLI_OPCODE 8'h58

`endif
